// ==== design/lsu_pkg.sv ====
// ################################################
// data path fixed at one 32-bit word, four byte lanes
// ################################################
package lsu_pkg;

    // word width, byte-lane logic assumes four lanes
    localparam int DATA_W = 32;
    // one strobe bit per byte lane
    localparam int STRB_W = DATA_W / 8;

    // access size, same encoding as funct3[1:0]
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2
    } mem_size_e;

    // load view, is_store is clear
    typedef struct packed {
        logic      is_store;
        logic      is_unsigned;
        mem_size_e size;
    } load_op_t;

    // store view, is_store is set
    typedef struct packed {
        logic      is_store;
        // unused for stores, keeps the layout of the load view
        logic      rsvd;
        mem_size_e size;
    } store_op_t;

    // one 4-bit operation word
    // is_store sits in bit 3 in both views and picks the view
    typedef union packed {
        load_op_t  ld;
        store_op_t st;
    } lsu_op_u;

    // axi response code for a good transfer
    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

// ==== design/lsu_req_if.sv ====
// ################################################
// fields are held from acceptance to writeback
// ################################################
interface lsu_req_if #(
    parameter int ADDR_W = 32
) ();
    import lsu_pkg::*;

    // byte address of the access
    logic [ADDR_W-1:0] addr;
    // raw store data, lane placement happens downstream
    logic [DATA_W-1:0] wdata;
    lsu_op_u           op;
    // destination register
    logic [4:0]        rd;

    // control side owns the latched request
    modport ctrl (output addr, wdata, op, rd);
    // datapath blocks only look at it
    modport dp (input addr, wdata, op, rd);

endinterface

// ==== design/lsu_ctrl.sv ====
// ################################################
// one transaction outstanding, no bursts or ids
// ################################################
module lsu_ctrl #(
    parameter int ADDR_W = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    // request from execute
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  lsu_pkg::lsu_op_u            req_op_i,
    input  logic [ADDR_W-1:0]           req_addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]  req_wdata_i,
    input  logic [4:0]                  req_rd_i,
    lsu_req_if.ctrl                     req,
    // extended load data from the datapath
    input  logic [lsu_pkg::DATA_W-1:0]  ld_data_i,
    // axi handshakes
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    input  logic [1:0]                  r_resp_i,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    input  logic [1:0]                  b_resp_i,
    input  logic                        b_valid_i,
    output logic                        b_ready_o,
    // writeback record
    output logic                        wb_valid_o,
    input  logic                        wb_ready_i,
    output logic [4:0]                  wb_rd_o,
    output logic [lsu_pkg::DATA_W-1:0]  wb_data_o,
    output logic                        wb_we_o,
    output logic                        wb_err_o
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ADDR,
        ST_RWAIT,
        ST_BWAIT,
        ST_RESP
    } state_e;

    state_e state;
    state_e state_nxt;
    // aw and w may finish in either order
    logic   aw_done;
    logic   w_done;
    logic   req_fire;
    logic   aw_fire;
    logic   w_fire;
    logic   r_fire;
    logic   b_fire;
    logic   is_store;

    assign is_store = req.op.st.is_store;

    // handshake strobes
    assign req_fire = req_valid_i & req_ready_o;
    assign aw_fire  = aw_valid_o & aw_ready_i;
    assign w_fire   = w_valid_o & w_ready_i;
    assign r_fire   = r_valid_i & r_ready_o;
    assign b_fire   = b_valid_i & b_ready_o;

    // outputs straight from state
    assign req_ready_o = (state == ST_IDLE);
    assign ar_valid_o  = (state == ST_ADDR) & ~is_store;
    assign aw_valid_o  = (state == ST_ADDR) & is_store & ~aw_done;
    assign w_valid_o   = (state == ST_ADDR) & is_store & ~w_done;
    assign r_ready_o   = (state == ST_RWAIT);
    assign b_ready_o   = (state == ST_BWAIT);
    assign wb_valid_o  = (state == ST_RESP);
    // rd is held until writeback is taken
    assign wb_rd_o     = req.rd;

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (req_fire) state_nxt = ST_ADDR;
            end
            ST_ADDR: begin
                if (!is_store) begin
                    if (ar_ready_i) state_nxt = ST_RWAIT;
                end else if ((aw_done | aw_fire) & (w_done | w_fire)) begin
                    state_nxt = ST_BWAIT;
                end
            end
            ST_RWAIT: begin
                if (r_fire) state_nxt = ST_RESP;
            end
            ST_BWAIT: begin
                if (b_fire) state_nxt = ST_RESP;
            end
            ST_RESP: begin
                if (wb_ready_i) state_nxt = ST_IDLE;
            end
            default: state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            state <= state_nxt;
            // done flags start clear for every new request
            if (req_fire) begin
                aw_done <= 1'b0;
                w_done  <= 1'b0;
            end else begin
                if (aw_fire) aw_done <= 1'b1;
                if (w_fire) w_done <= 1'b1;
            end
        end
    end

    // request latch, feeds both datapath blocks
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req.addr  <= req_addr_i;
            req.wdata <= req_wdata_i;
            req.op    <= req_op_i;
            req.rd    <= req_rd_i;
        end
    end

    // record captured on the last axi handshake
    always_ff @(posedge clk) begin
        if (r_fire) begin
            wb_err_o  <= (r_resp_i != RESP_OKAY);
            wb_we_o   <= (r_resp_i == RESP_OKAY);
            // errored loads return zero
            wb_data_o <= (r_resp_i == RESP_OKAY) ? ld_data_i : '0;
        end else if (b_fire) begin
            wb_err_o  <= (b_resp_i != RESP_OKAY);
            wb_we_o   <= 1'b0;
            wb_data_o <= '0;
        end
    end

endmodule

// ==== design/lsu_store_align.sv ====
// ################################################
// address must be naturally aligned for its size
// ################################################
module lsu_store_align #(
    parameter int ADDR_W = 32
) (
    lsu_req_if.dp                       req,
    output logic [ADDR_W-1:0]           aw_addr_o,
    output logic [lsu_pkg::DATA_W-1:0]  w_data_o,
    output logic [lsu_pkg::STRB_W-1:0]  w_strb_o
);
    import lsu_pkg::*;

    // low address bits pick the lane
    logic [1:0] lane;

    assign lane      = req.addr[1:0];
    // write address is the latched byte address
    assign aw_addr_o = req.addr;

    always_comb begin
        case (req.op.st.size)
            SIZE_B: begin
                // byte copied into every lane
                w_data_o = {STRB_W{req.wdata[7:0]}};
                w_strb_o = STRB_W'(1) << lane;
            end
            SIZE_H: begin
                // halfword copied into both halves
                w_data_o = {(STRB_W / 2){req.wdata[15:0]}};
                w_strb_o = STRB_W'(2'b11) << {lane[1], 1'b0};
            end
            default: begin
                // full word, all lanes
                w_data_o = req.wdata;
                w_strb_o = {STRB_W{1'b1}};
            end
        endcase
    end

endmodule

// ==== design/lsu_load_extend.sv ====
// ################################################
// aligned loads only, lane picked by addr[1:0]
// ################################################
module lsu_load_extend #(
    parameter int ADDR_W = 32
) (
    lsu_req_if.dp                       req,
    input  logic [lsu_pkg::DATA_W-1:0]  r_data_i,
    output logic [ADDR_W-1:0]           ar_addr_o,
    output logic [lsu_pkg::DATA_W-1:0]  ld_data_o
);
    import lsu_pkg::*;

    // read word with the addressed lane moved to bit 0
    logic [DATA_W-1:0] lane_word;
    logic              sign_bit;

    assign ar_addr_o = req.addr;

    always_comb begin
        lane_word = r_data_i >> {req.addr[1:0], 3'b000};
        sign_bit  = 1'b0;
        case (req.op.ld.size)
            SIZE_B: begin
                // lbu keeps the top bits clear
                sign_bit  = lane_word[7] & ~req.op.ld.is_unsigned;
                ld_data_o = {{(DATA_W - 8){sign_bit}}, lane_word[7:0]};
            end
            SIZE_H: begin
                sign_bit  = lane_word[15] & ~req.op.ld.is_unsigned;
                ld_data_o = {{(DATA_W - 16){sign_bit}}, lane_word[15:0]};
            end
            default: begin
                // lw, shift is zero for an aligned word
                ld_data_o = lane_word;
            end
        endcase
    end

endmodule

// ==== design/lsu_top.sv ====
// ################################################
// axi4-lite master, one access at a time, aligned only
// ################################################
module lsu_top #(
    parameter int ADDR_W = 32
) (
    input  logic                        clk,
    input  logic                        rst,
    // execute side
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  lsu_pkg::lsu_op_u            req_op_i,
    input  logic [ADDR_W-1:0]           req_addr_i,
    input  logic [lsu_pkg::DATA_W-1:0]  req_wdata_i,
    input  logic [4:0]                  req_rd_i,
    // read address and data
    output logic [ADDR_W-1:0]           ar_addr_o,
    output logic                        ar_valid_o,
    input  logic                        ar_ready_i,
    input  logic [lsu_pkg::DATA_W-1:0]  r_data_i,
    input  logic [1:0]                  r_resp_i,
    input  logic                        r_valid_i,
    output logic                        r_ready_o,
    // write address, data and response
    output logic [ADDR_W-1:0]           aw_addr_o,
    output logic                        aw_valid_o,
    input  logic                        aw_ready_i,
    output logic [lsu_pkg::DATA_W-1:0]  w_data_o,
    output logic [lsu_pkg::STRB_W-1:0]  w_strb_o,
    output logic                        w_valid_o,
    input  logic                        w_ready_i,
    input  logic [1:0]                  b_resp_i,
    input  logic                        b_valid_i,
    output logic                        b_ready_o,
    // register file side
    output logic                        wb_valid_o,
    input  logic                        wb_ready_i,
    output logic [4:0]                  wb_rd_o,
    output logic [lsu_pkg::DATA_W-1:0]  wb_data_o,
    output logic                        wb_we_o,
    output logic                        wb_err_o
);
    import lsu_pkg::*;

    // extended load data into the record
    logic [DATA_W-1:0] ld_data;

    lsu_req_if #(.ADDR_W(ADDR_W)) req_if ();

    lsu_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_rd_i    (req_rd_i),
        .req         (req_if.ctrl),
        .ld_data_i   (ld_data),
        .ar_valid_o  (ar_valid_o),
        .ar_ready_i  (ar_ready_i),
        .r_resp_i    (r_resp_i),
        .r_valid_i   (r_valid_i),
        .r_ready_o   (r_ready_o),
        .aw_valid_o  (aw_valid_o),
        .aw_ready_i  (aw_ready_i),
        .w_valid_o   (w_valid_o),
        .w_ready_i   (w_ready_i),
        .b_resp_i    (b_resp_i),
        .b_valid_i   (b_valid_i),
        .b_ready_o   (b_ready_o),
        .wb_valid_o  (wb_valid_o),
        .wb_ready_i  (wb_ready_i),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o),
        .wb_we_o     (wb_we_o),
        .wb_err_o    (wb_err_o)
    );

    lsu_store_align #(.ADDR_W(ADDR_W)) u_store_align (
        .req       (req_if.dp),
        .aw_addr_o (aw_addr_o),
        .w_data_o  (w_data_o),
        .w_strb_o  (w_strb_o)
    );

    lsu_load_extend #(.ADDR_W(ADDR_W)) u_load_extend (
        .req       (req_if.dp),
        .r_data_i  (r_data_i),
        .ar_addr_o (ar_addr_o),
        .ld_data_o (ld_data)
    );

endmodule

// ==== testbench/lsu_checker.sv ====
// ################################################
// axi and writeback handshake rules, aligned requests only
// ################################################
module lsu_checker #(
    parameter int ADDR_W = 32
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        req_valid_i,
    input logic                        req_ready_o,
    input lsu_pkg::lsu_op_u            req_op_i,
    input logic [ADDR_W-1:0]           req_addr_i,
    input logic                        ar_valid_o,
    input logic                        ar_ready_i,
    input logic [ADDR_W-1:0]           ar_addr_o,
    input logic                        aw_valid_o,
    input logic                        aw_ready_i,
    input logic [ADDR_W-1:0]           aw_addr_o,
    input logic                        w_valid_o,
    input logic                        w_ready_i,
    input logic [lsu_pkg::DATA_W-1:0]  w_data_o,
    input logic [lsu_pkg::STRB_W-1:0]  w_strb_o,
    input logic                        wb_valid_o,
    input logic                        wb_ready_i,
    input logic [lsu_pkg::DATA_W-1:0]  wb_data_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    // valid and payload held until ready
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o))
        else $error("ar_valid_o dropped or ar_addr_o changed before ar_ready_i");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
        else $error("aw_valid_o dropped or aw_addr_o changed before aw_ready_i");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o))
        else $error("w_valid_o dropped or write data changed before w_ready_i");
    wb_hold: assert property (@(posedge clk) disable iff (rst)
        wb_valid_o && !wb_ready_i |=> wb_valid_o && $stable(wb_data_o))
        else $error("wb_valid_o dropped or wb_data_o changed before wb_ready_i");
    // busy means no new request
    busy_no_req: assert property (@(posedge clk) disable iff (rst)
        (ar_valid_o || aw_valid_o || w_valid_o || wb_valid_o) |-> !req_ready_o)
        else $error("req_ready_o high while a transaction is in flight");
    aligned: assert property (@(posedge clk) disable iff (rst)
        req_valid_i && req_ready_o |->
            (req_op_i.ld.size == SIZE_B)
            || (req_op_i.ld.size == SIZE_H && !req_addr_i[0])
            || (req_addr_i[1:0] == 2'b00))
        else $error("accepted address not naturally aligned");

endmodule

bind lsu_top lsu_checker #(.ADDR_W(ADDR_W)) u_checker (
    .clk(clk), .rst(rst), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
    .req_op_i(req_op_i), .req_addr_i(req_addr_i), .ar_valid_o(ar_valid_o),
    .ar_ready_i(ar_ready_i), .ar_addr_o(ar_addr_o), .aw_valid_o(aw_valid_o),
    .aw_ready_i(aw_ready_i), .aw_addr_o(aw_addr_o), .w_valid_o(w_valid_o),
    .w_ready_i(w_ready_i), .w_data_o(w_data_o), .w_strb_o(w_strb_o),
    .wb_valid_o(wb_valid_o), .wb_ready_i(wb_ready_i), .wb_data_o(wb_data_o)
);

// ==== testbench/lsu_tb.sv ====
// ################################################
// memory model covers 256 words and addr bit 10 answers slverr
// ################################################
module lsu_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import lsu_pkg::*;

    localparam int TIMEOUT = 3000;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic req_valid_i = 1'b0, ar_ready_i = 1'b0, r_valid_i = 1'b0, aw_ready_i = 1'b0;
    logic w_ready_i = 1'b0, b_valid_i = 1'b0, wb_ready_i = 1'b0;
    lsu_op_u req_op_i = '0;
    logic [31:0] req_addr_i = '0, req_wdata_i = '0, r_data_i = '0;
    logic [4:0] req_rd_i = '0;
    logic [1:0] r_resp_i = '0, b_resp_i = '0;
    logic req_ready_o, ar_valid_o, r_ready_o, aw_valid_o, w_valid_o, b_ready_o;
    logic wb_valid_o, wb_we_o, wb_err_o;
    logic [31:0] ar_addr_o, aw_addr_o, w_data_o, wb_data_o;
    logic [3:0] w_strb_o;
    logic [4:0] wb_rd_o;

    // slave memory and the reference copy
    logic [31:0] mem [256];
    logic [31:0] ref_mem [256];
    logic [31:0] rd_lfsr, aw_lfsr, w_lfsr, b_lfsr;
    logic [31:0] aw_addr_q, w_data_q;
    logic [3:0] w_strb_q;
    logic aw_got = 1'b0, w_got = 1'b0;
    int cycles = 0, errors = 0, checks = 0, aw_first = 0, w_first = 0;
    logic [4:0] rd_next = 5'd1;

    lsu_top #(.ADDR_W(32)) dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        // one channel finishing while the other still waits
        if (aw_valid_o && aw_ready_i && w_valid_o && !w_ready_i) aw_first <= aw_first + 1;
        if (w_valid_o && w_ready_i && aw_valid_o && !aw_ready_i) w_first <= w_first + 1;
    end

    // stop a hung run at the cycle limit
    initial begin : watchdog
        while (cycles < TIMEOUT) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per delay bit for 0 to 3 cycles
    task automatic draw_delay(inout logic [31:0] s, output int d);
        s = lfsr_next(s);
        d = s[0];
        s = lfsr_next(s);
        d = d + 2 * s[0];
    endtask

    function automatic lsu_op_u make_op(input logic st, input logic uns, input mem_size_e sz);
        lsu_op_u op;
        op.ld.is_store = st;
        op.ld.is_unsigned = uns;
        op.ld.size = sz;
        return op;
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] word, input mem_size_e sz,
                                                input logic uns, input logic [1:0] off);
        logic [31:0] v;
        v = word >> (8 * off);
        if (sz == SIZE_B) return uns ? {24'h0, v[7:0]} : {{24{v[7]}}, v[7:0]};
        if (sz == SIZE_H) return uns ? {16'h0, v[15:0]} : {{16{v[15]}}, v[15:0]};
        return word;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    initial begin : read_slave
        int d;
        logic [31:0] a;
        rd_lfsr = 32'd82235;
        forever begin
            @(posedge clk);
            if (!rst && ar_valid_o) begin
                draw_delay(rd_lfsr, d);
                repeat (d) @(posedge clk);
                ar_ready_i <= 1'b1;
                @(posedge clk);
                ar_ready_i <= 1'b0;
                a = ar_addr_o;
                draw_delay(rd_lfsr, d);
                repeat (d) @(posedge clk);
                r_valid_i <= 1'b1;
                r_resp_i <= a[10] ? RESP_SLVERR : RESP_OKAY;
                r_data_i <= a[10] ? 32'hbad0_0bad : mem[a[9:2]];
                do @(posedge clk); while (!r_ready_o);
                r_valid_i <= 1'b0;
            end
        end
    end

    initial begin : aw_slave
        int d;
        aw_lfsr = lfsr_next(32'd82235);
        forever begin
            @(posedge clk);
            if (!rst && aw_valid_o) begin
                draw_delay(aw_lfsr, d);
                repeat (d) @(posedge clk);
                aw_ready_i <= 1'b1;
                @(posedge clk);
                aw_ready_i <= 1'b0;
                aw_addr_q <= aw_addr_o;
                aw_got <= 1'b1;
            end
        end
    end

    initial begin : w_slave
        int d;
        w_lfsr = lfsr_next(lfsr_next(lfsr_next(32'd82235)));
        forever begin
            @(posedge clk);
            if (!rst && w_valid_o) begin
                draw_delay(w_lfsr, d);
                repeat (d) @(posedge clk);
                w_ready_i <= 1'b1;
                @(posedge clk);
                w_ready_i <= 1'b0;
                w_data_q <= w_data_o;
                w_strb_q <= w_strb_o;
                w_got <= 1'b1;
            end
        end
    end

    initial begin : b_slave
        int d;
        b_lfsr = 32'd82235 ^ 32'h0000_5a5a;
        forever begin
            @(posedge clk);
            if (aw_got && w_got) begin
                aw_got <= 1'b0;
                w_got <= 1'b0;
                // error region leaves memory alone
                for (int i = 0; i < 4; i++)
                    if (!aw_addr_q[10] && w_strb_q[i])
                        mem[aw_addr_q[9:2]][8*i +: 8] = w_data_q[8*i +: 8];
                draw_delay(b_lfsr, d);
                repeat (d) @(posedge clk);
                b_valid_i <= 1'b1;
                b_resp_i <= aw_addr_q[10] ? RESP_SLVERR : RESP_OKAY;
                do @(posedge clk); while (!b_ready_o);
                b_valid_i <= 1'b0;
            end
        end
    end

    // one request with the record sampled at wb_valid_o
    task automatic access(input lsu_op_u op, input logic [31:0] addr, input logic [31:0] wdata,
                          input int hold, output logic [31:0] data, output logic we,
                          output logic err);
        logic [4:0] rd;
        rd = rd_next;
        rd_next = rd_next + 5'd1;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_op_i <= op;
        req_addr_i <= addr;
        req_wdata_i <= wdata;
        req_rd_i <= rd;
        do @(posedge clk); while (!req_ready_o);
        req_valid_i <= 1'b0;
        do @(posedge clk); while (!wb_valid_o);
        data = wb_data_o;
        we = wb_we_o;
        err = wb_err_o;
        check("wb_rd_o", 32'(wb_rd_o), 32'(rd));
        // back-pressure keeps the record frozen
        repeat (hold) begin
            @(posedge clk);
            check("wb_valid_o", 32'(wb_valid_o), 32'd1);
            check("wb_data_o", wb_data_o, data);
            check("wb_we_o", 32'(wb_we_o), 32'(we));
            check("wb_err_o", 32'(wb_err_o), 32'(err));
            check("req_ready_o", 32'(req_ready_o), 32'd0);
        end
        wb_ready_i <= 1'b1;
        @(posedge clk);
        wb_ready_i <= 1'b0;
    endtask

    task automatic store(input mem_size_e sz, input logic [31:0] addr, input logic [31:0] wdata,
                         input int hold);
        logic [31:0] data;
        logic we, err;
        int n;
        access(make_op(1'b1, 1'b0, sz), addr, wdata, hold, data, we, err);
        n = (sz == SIZE_B) ? 1 : (sz == SIZE_H) ? 2 : 4;
        if (!addr[10])
            for (int i = 0; i < n; i++)
                ref_mem[addr[9:2]][8*(addr[1:0] + i) +: 8] = wdata[8*i +: 8];
        check("wb_we_o", 32'(we), 32'd0);
        check("wb_err_o", 32'(err), 32'(addr[10]));
        check("wb_data_o", data, 32'd0);
        check("memory word", mem[addr[9:2]], ref_mem[addr[9:2]]);
    endtask

    task automatic load(input mem_size_e sz, input logic uns, input logic [31:0] addr,
                        input int hold);
        logic [31:0] data;
        logic we, err;
        access(make_op(1'b0, uns, sz), addr, 32'h0, hold, data, we, err);
        check("wb_err_o", 32'(err), 32'(addr[10]));
        check("wb_we_o", 32'(we), 32'(!addr[10]));
        check("wb_data_o", data,
              addr[10] ? 32'd0 : expect_load(ref_mem[addr[9:2]], sz, uns, addr[1:0]));
    endtask

    task automatic reset_values();
        @(posedge clk);
        check("req_ready_o", 32'(req_ready_o), 32'd1);
        check("ar_valid_o", 32'(ar_valid_o), 32'd0);
        check("aw_valid_o", 32'(aw_valid_o), 32'd0);
        check("w_valid_o", 32'(w_valid_o), 32'd0);
        check("r_ready_o", 32'(r_ready_o), 32'd0);
        check("b_ready_o", 32'(b_ready_o), 32'd0);
        check("wb_valid_o", 32'(wb_valid_o), 32'd0);
        $display("test reset done, errors so far %0d", errors);
    endtask

    task automatic word_round_trip();
        store(SIZE_W, 32'h40, 32'h1234_abcd, 0);
        load(SIZE_W, 1'b0, 32'h40, 0);
        $display("test word store and load done, errors so far %0d", errors);
    endtask

    task automatic lane_merge();
        store(SIZE_W, 32'h100, 32'hc3a5_5a3c, 0);
        for (int off = 0; off < 4; off++)
            store(SIZE_B, 32'h100 + off, 32'hffff_ff80 + 32'h13 * off, 0);
        load(SIZE_W, 1'b0, 32'h100, 0);
        for (int off = 0; off < 4; off++) begin
            load(SIZE_B, 1'b0, 32'h100 + off, 0);
            load(SIZE_B, 1'b1, 32'h100 + off, 0);
        end
        store(SIZE_H, 32'h100, 32'h5555_8765, 0);
        store(SIZE_H, 32'h102, 32'haaaa_7f01, 0);
        load(SIZE_W, 1'b0, 32'h100, 0);
        for (int off = 0; off < 4; off += 2) begin
            load(SIZE_H, 1'b0, 32'h100 + off, 0);
            load(SIZE_H, 1'b1, 32'h100 + off, 0);
        end
        $display("test byte and halfword lanes done, errors so far %0d", errors);
    endtask

    task automatic random_stalls();
        for (int i = 0; i < 8; i++)
            store(SIZE_W, 32'h200 + 4 * i, (32'h0101_0101 * i) ^ 32'h5a5a_0f0f, 4);
        for (int i = 0; i < 8; i++)
            load(SIZE_W, 1'b0, 32'h200 + 4 * i, 3);
        if (aw_first == 0 || w_first == 0) begin
            errors++;
            $display("stores did not see aw and w complete in both orders");
        end
        $display("test stalls done, aw first %0d, w first %0d, errors so far %0d",
                 aw_first, w_first, errors);
    endtask

    task automatic slave_errors();
        load(SIZE_W, 1'b0, 32'h410, 0);
        store(SIZE_W, 32'h404, 32'hfeed_f00d, 0);
        store(SIZE_W, 32'h80, 32'h0bad_cafe, 0);
        load(SIZE_W, 1'b0, 32'h80, 0);
        $display("test slave errors done, errors so far %0d", errors);
    endtask

    initial begin
        // fill depends on the whole word index
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'h9e37_79b9 * (i + 1)) ^ (i << 24);
            ref_mem[i] = mem[i];
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        reset_values();
        word_round_trip();
        lane_merge();
        random_stalls();
        slave_errors();
        $display("checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
design/lsu_pkg.sv
design/lsu_req_if.sv
design/lsu_ctrl.sv
design/lsu_store_align.sv
design/lsu_load_extend.sv
design/lsu_top.sv
testbench/lsu_checker.sv
testbench/lsu_tb.sv

// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module lsu_tb -f all.f

sim:
	verilator --binary --timing --assert --top-module lsu_tb -Mdir obj_dir -f all.f
	out=$$(./obj_dir/Vlsu_tb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
